// ==== bench/tb_rv_encode.svh ====
`ifndef TB_RV_ENCODE_SVH
`define TB_RV_ENCODE_SVH

// instruction builders, low bits always 11
function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3, reg_idx_t rd, opcode_e opc);
   return {f7, rs2, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                reg_idx_t rd, opcode_e opc);
   return {imm, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE, 2'b11};
endfunction

// branch offset, bit 0 dropped by the format
function automatic word_t enc_b(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3);
   return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH, 2'b11};
endfunction

function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, opcode_e opc);
   return {imm, rd, opc, 2'b11};
endfunction

function automatic word_t enc_j(logic [20:0] off, reg_idx_t rd);
   return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL, 2'b11};
endfunction

// expected immediates, sign extended from the top bit
function automatic word_t sext12(logic [11:0] v);
   return {{20{v[11]}}, v};
endfunction

function automatic word_t sext13(logic [12:0] v);
   return {{19{v[12]}}, v};
endfunction

function automatic word_t sext21(logic [20:0] v);
   return {{11{v[20]}}, v};
endfunction

`endif

// ==== bench/tb_rv_decoder.sv ====
`timescale 1ns/1ps

module tb_rv_decoder;
   import rv_decode_pkg::*;

   `include "tb_rv_encode.svh"

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_VECTORS  = 3 + 24 + 24 + 8 + 4 + 12; // strobes per test in run order

   logic         i_clk = 1'b0;
   logic         i_reset;
   logic         i_en;
   word_t        i_instr;
   logic         o_valid;
   reg_fields_t  o_regs;
   word_t        o_imm;
   decode_ctrl_t o_ctrl;

   integer seed    = 32'h72ad14e8;
   int     errors  = 0;
   int     vectors = 0;                       // strobes sent

   rv_decoder #(.ENABLE_M_EXT(1'b1)) dut_i (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_en    (i_en),
      .i_instr (i_instr),
      .o_valid (o_valid),
      .o_regs  (o_regs),
      .o_imm   (o_imm),
      .o_ctrl  (o_ctrl)
   );

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
      if (expected !== actual) begin
         $display("Error: %s expected %h got %h at %0t", name, expected, actual, $time);
         errors++;
      end
   endtask

   // default control word with only stage and funct3 set
   function automatic decode_ctrl_t ctrl_for(exec_stage_e stage, logic [2:0] f3);
      decode_ctrl_t c;
      c               = '0;
      c.alu_op        = ALU_ADD;
      c.alu_s1_sel    = S1_REGVAL1;
      c.alu_s2_sel    = S2_REGVAL2;
      c.reg_input_sel = RIN_ALU;
      c.next_stage    = stage;
      c.funct3        = f3;
      return c;
   endfunction

   // kind is 0 for base, 1 for alt funct7 and 2 for muldiv
   function automatic alu_op_e r_type_alu(int kind, logic [2:0] f3);
      alu_op_e base [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                            ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
      alu_op_e mdiv [8] = '{ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
                            ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
      if (kind == 2) return mdiv[f3];
      if (kind == 1 && f3 == 3'b000) return ALU_SUB;
      if (kind == 1 && f3 == 3'b101) return ALU_SRA;
      return base[f3];
   endfunction

   // one strobe that returns at the falling edge with the result on the outputs
   task automatic send(word_t w);
      @(negedge i_clk);
      i_en    = 1'b1;
      i_instr = w;
      @(posedge i_clk);
      @(negedge i_clk);
      i_en = 1'b0;
      vectors++;
      check_value("o_valid", 32'd1, 32'(o_valid));
   endtask

   task automatic reset_timing();
      reg_idx_t rd_a;
      reg_idx_t rd_b;
      rd_a = 5'($random(seed));
      rd_b = rd_a ^ 5'h15;                    // never equal to rd_a
      @(negedge i_clk);
      check_value("o_valid", 32'd0, 32'(o_valid)); // idle after reset
      check_value("o_ctrl", 32'(ctrl_for(STAGE_FETCH, 3'b000)), 32'(o_ctrl));
      send(enc_i(12'h001, 5'd1, 3'b000, rd_a, OPC_OPIMM));
      check_value("o_regs.rd", 32'(rd_a), 32'(o_regs.rd));
      i_instr = enc_i(12'h7ff, 5'd4, 3'b000, rd_b, OPC_OPIMM); // no strobe with it
      @(negedge i_clk);
      check_value("o_valid", 32'd0, 32'(o_valid)); // pulse is one cycle
      check_value("o_regs.rd", 32'(rd_a), 32'(o_regs.rd)); // held until next strobe
      check_value("o_imm", 32'h1, o_imm);
      i_en    = 1'b1;                         // back to back pair
      i_instr = enc_i(12'h002, 5'd2, 3'b000, rd_b, OPC_OPIMM);
      @(negedge i_clk);
      check_value("o_valid", 32'd1, 32'(o_valid));
      check_value("o_regs.rd", 32'(rd_b), 32'(o_regs.rd));
      i_instr = enc_i(12'h003, 5'd3, 3'b000, rd_a, OPC_OPIMM);
      @(negedge i_clk);
      i_en = 1'b0;
      check_value("o_valid", 32'd1, 32'(o_valid));
      check_value("o_regs.rd", 32'(rd_a), 32'(o_regs.rd));
      @(negedge i_clk);
      check_value("o_valid", 32'd0, 32'(o_valid));
      vectors += 2;
   endtask

   task automatic r_type_ops();
      reg_idx_t     rs1, rs2, rd;
      logic [6:0]   f7;
      logic [2:0]   f3;
      decode_ctrl_t ec;
      for (int k = 0; k < 3; k++) begin
         f7 = (k == 0) ? 7'b0000000 : (k == 1) ? FUNCT7_ALT : FUNCT7_MULDIV;
         for (int f = 0; f < 8; f++) begin
            f3  = 3'(f);
            rs1 = 5'($random(seed));
            rs2 = 5'($random(seed));
            rd  = 5'($random(seed));
            send(enc_r(f7, rs2, rs1, f3, rd, OPC_OP));
            ec             = ctrl_for(STAGE_FETCH, f3);
            ec.alu_op      = r_type_alu(k, f3);
            ec.wb_from_alu = 1'b1;
            check_value("o_ctrl", 32'(ec), 32'(o_ctrl));
            check_value("o_regs", 32'({rs1, rs2, rd}), 32'(o_regs));
         end
      end
   endtask

   task automatic imm_and_memory_ops();
      logic [11:0]  imm;
      logic [2:0]   f3;
      decode_ctrl_t ec;
      for (int i = 0; i < 8; i++) begin
         f3  = 3'(i);
         imm = 12'($random(seed));
         send(enc_i(imm, 5'($random(seed)), f3, 5'($random(seed)), OPC_OPIMM));
         ec             = ctrl_for(STAGE_FETCH, f3);
         ec.alu_op      = r_type_alu((f3 == 3'b101 && imm[10]) ? 1 : 0, f3); // bit 30 picks sra
         ec.alu_s2_sel  = S2_IMM;
         ec.wb_from_alu = 1'b1;
         check_value("o_ctrl", 32'(ec), 32'(o_ctrl));
         check_value("o_imm", sext12(imm), o_imm);
         imm = 12'($random(seed));
         send(enc_i(imm, 5'($random(seed)), f3, 5'($random(seed)), OPC_LOAD));
         ec            = ctrl_for(STAGE_LOAD, f3);
         ec.alu_s2_sel = S2_IMM;
         check_value("o_ctrl", 32'(ec), 32'(o_ctrl));
         check_value("o_imm", sext12(imm), o_imm);
         imm = 12'($random(seed));
         send(enc_s(imm, 5'($random(seed)), 5'($random(seed)), f3));
         ec            = ctrl_for(STAGE_STORE, f3);
         ec.alu_s2_sel = S2_IMM;
         check_value("o_ctrl", 32'(ec), 32'(o_ctrl));
         check_value("o_imm", sext12(imm), o_imm);
      end
   endtask

   task automatic branch_ops();
      logic [12:0]  off;
      logic [2:0]   f3;
      decode_ctrl_t ec;
      for (int f = 0; f < 8; f++) begin
         f3  = 3'(f);
         off = {12'($random(seed)), 1'b0};    // even offset
         send(enc_b(off, 5'($random(seed)), 5'($random(seed)), f3));
         ec = ctrl_for(STAGE_BRANCH, f3);
         if (f3 < 3'd2) ec.branch_mask[f3] = 1'b1;
         else if (f3 >= 3'd4) ec.branch_mask[f3 - 3'd2] = 1'b1; // 010 and 011 stay 0
         check_value("o_ctrl", 32'(ec), 32'(o_ctrl));
         check_value("o_imm", sext13(off), o_imm);
      end
   endtask

   task automatic jump_and_upper_ops();
      logic [20:0]  off;
      logic [11:0]  imm;
      logic [19:0]  upper;
      word_t        w;
      decode_ctrl_t ec;
      off = {20'($random(seed)), 1'b0};
      w   = enc_j(off, 5'($random(seed)));
      send(w);
      ec                  = ctrl_for(STAGE_FETCH, off[14:12]);
      ec.alu_s1_sel       = S1_PC;
      ec.alu_s2_sel       = S2_IMM;
      ec.write_reg        = 1'b1;
      ec.next_pc_from_alu = 1'b1;
      check_value("o_ctrl", 32'(ec), 32'(o_ctrl));
      check_value("o_imm", sext21(off), o_imm);
      imm = 12'($random(seed));
      send(enc_i(imm, 5'($random(seed)), 3'b000, 5'($random(seed)), OPC_JALR));
      ec.alu_s1_sel = S1_REGVAL1;             // rest as jal
      ec.funct3     = 3'b000;
      check_value("o_ctrl", 32'(ec), 32'(o_ctrl));
      check_value("o_imm", sext12(imm), o_imm);
      upper = 20'($random(seed));
      w     = enc_u(upper, 5'($random(seed)), OPC_LUI);
      send(w);
      ec               = ctrl_for(STAGE_FETCH, upper[2:0]);
      ec.wb_from_imm   = 1'b1;
      ec.reg_input_sel = RIN_IMM;
      check_value("o_ctrl", 32'(ec), 32'(o_ctrl));
      check_value("o_imm", {upper, 12'h000}, o_imm);
      w = enc_u(upper, 5'($random(seed)), OPC_AUIPC);
      send(w);
      ec             = ctrl_for(STAGE_FETCH, upper[2:0]);
      ec.alu_s1_sel  = S1_PC;
      ec.alu_s2_sel  = S2_IMM;
      ec.wb_from_alu = 1'b1;
      check_value("o_ctrl", 32'(ec), 32'(o_ctrl));
      check_value("o_imm", {upper, 12'h000}, o_imm);
   endtask

   task automatic illegal_words();
      logic [4:0] bad_opc [3] = '{5'b00010, 5'b00111, 5'b11111}; // not in the opcode map
      word_t      w;
      for (int i = 0; i < 12; i++) begin
         if (i < 3) begin
            w = {25'($random(seed)), bad_opc[i], 2'b11};
         end else if (i == 3) begin
            w      = enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP);
            w[1:0] = 2'b01;                   // compressed form
         end else begin
            w    = $random(seed);
            w[0] = 1'b0;                      // low pair 00 or 10
         end
         send(w);
         check_value("o_ctrl", 32'(ctrl_for(STAGE_TRAP, w[14:12])), 32'(o_ctrl));
      end
   endtask

   initial begin : watchdog
      #((NUM_VECTORS * 4 + RESET_CYCLES + 100) * CLK_PERIOD);
      $display("Timeout: the decoder tests did not finish in the allowed time");
      $display("Test failures found");
      $finish;
   end

   initial begin
      i_reset = 1'b1;
      i_en    = 1'b0;
      i_instr = '0;
      repeat (RESET_CYCLES) @(posedge i_clk);
      @(negedge i_clk);
      check_value("o_valid", 32'd0, 32'(o_valid)); // still in reset
      check_value("o_ctrl", 32'(ctrl_for(STAGE_FETCH, 3'b000)), 32'(o_ctrl));
      check_value("o_imm", 32'h0, o_imm);
      check_value("o_regs", 32'h0, 32'(o_regs));
      i_reset = 1'b0;
      reset_timing();
      r_type_ops();
      imm_and_memory_ops();
      branch_ops();
      jump_and_upper_ops();
      illegal_words();
      $display("Summary: %0d strobes sent, %0d errors", vectors, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+bench
src/rv_decode_pkg.sv
src/imm_gen.sv
src/ctrl_decode.sv
src/rv_decoder.sv
bench/tb_rv_decoder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv_decoder testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module tb_rv_decoder -o tb_rv_decoder
./obj_dir/tb_rv_decoder | tee sim.log
if grep -q "All tests passed!" sim.log; then
   echo "simulation PASS"
else
   echo "simulation FAIL, see sim.log"
   exit 1
fi

// ==== src/ctrl_decode.sv ====
`timescale 1ns/1ps

module ctrl_decode #(
   parameter bit ENABLE_M_EXT = 1'b1
) (
   input  rv_decode_pkg::word_t        i_instr,
   output rv_decode_pkg::reg_fields_t  o_regs,
   output rv_decode_pkg::decode_ctrl_t o_ctrl
);
   import rv_decode_pkg::*;

   opcode_e    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       is_alt;                        // sub/sra variant
   alu_op_e    op_alu;                        // alu op for OP class
   logic       op_legal;                      // funct7 accepted for OP
   alu_op_e    opimm_alu;                     // alu op for OP-IMM class

   assign opcode = opcode_e'(i_instr[6:2]);
   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];
   assign is_alt = (funct7 == FUNCT7_ALT);

   // register-register ops, funct7 picks base, alt or muldiv
   always_comb begin
      op_alu   = ALU_ADD;
      op_legal = 1'b1;
      case (funct7)
         FUNCT7_MULDIV: begin
            op_legal = ENABLE_M_EXT;          // trap when M is left out
            case (funct3)
               F3_ADD_SUB: op_alu = ALU_MUL;
               F3_SLL:     op_alu = ALU_MULH;
               F3_SLT:     op_alu = ALU_MULHSU;
               F3_SLTU:    op_alu = ALU_MULHU;
               F3_XOR:     op_alu = ALU_DIV;
               F3_SRL_SRA: op_alu = ALU_DIVU;
               F3_OR:      op_alu = ALU_REM;
               F3_AND:     op_alu = ALU_REMU;
               default:    op_alu = ALU_ADD;
            endcase
         end
         FUNCT7_BASE, FUNCT7_ALT: begin
            case (funct3)
               F3_ADD_SUB: op_alu = is_alt ? ALU_SUB : ALU_ADD;
               F3_SLL:     op_alu = ALU_SLL;  // alt bit ignored here
               F3_SLT:     op_alu = ALU_SLT;
               F3_SLTU:    op_alu = ALU_SLTU;
               F3_XOR:     op_alu = ALU_XOR;
               F3_SRL_SRA: op_alu = is_alt ? ALU_SRA : ALU_SRL;
               F3_OR:      op_alu = ALU_OR;
               F3_AND:     op_alu = ALU_AND;
               default:    op_alu = ALU_ADD;
            endcase
         end
         default: op_legal = 1'b0;            // unknown funct7
      endcase
   end

   // immediate ops, no sub, bit 30 only matters for shifts
   always_comb begin
      case (funct3)
         F3_SLL:     opimm_alu = ALU_SLL;
         F3_SLT:     opimm_alu = ALU_SLT;
         F3_SLTU:    opimm_alu = ALU_SLTU;
         F3_XOR:     opimm_alu = ALU_XOR;
         F3_SRL_SRA: opimm_alu = funct7[5] ? ALU_SRA : ALU_SRL;
         F3_OR:      opimm_alu = ALU_OR;
         F3_AND:     opimm_alu = ALU_AND;
         default:    opimm_alu = ALU_ADD;     // addi
      endcase
   end

   always_comb begin
      o_regs.rs1 = i_instr[19:15];
      o_regs.rs2 = i_instr[24:20];
      o_regs.rd  = i_instr[11:7];

      o_ctrl                  = '0;           // all flags and mask low
      o_ctrl.alu_op           = ALU_ADD;
      o_ctrl.alu_s1_sel       = S1_REGVAL1;
      o_ctrl.alu_s2_sel       = S2_REGVAL2;
      o_ctrl.reg_input_sel    = RIN_ALU;
      o_ctrl.next_stage       = STAGE_TRAP;   // unless recognised below
      o_ctrl.funct3           = funct3;

      if (i_instr[1:0] == LEN_32) begin
         case (opcode)
            OPC_OP: begin
               if (op_legal) begin
                  o_ctrl.alu_op      = op_alu;
                  o_ctrl.wb_from_alu = 1'b1;
                  o_ctrl.next_stage  = STAGE_FETCH;
               end
            end
            OPC_OPIMM: begin
               o_ctrl.alu_op      = opimm_alu;
               o_ctrl.alu_s2_sel  = S2_IMM;
               o_ctrl.wb_from_alu = 1'b1;
               o_ctrl.next_stage  = STAGE_FETCH;
            end
            OPC_LOAD: begin                   // address = rs1 + imm
               o_ctrl.alu_s2_sel = S2_IMM;
               o_ctrl.next_stage = STAGE_LOAD;
            end
            OPC_STORE: begin
               o_ctrl.alu_s2_sel = S2_IMM;
               o_ctrl.next_stage = STAGE_STORE;
            end
            OPC_JAL, OPC_JALR: begin          // link written, target from alu
               o_ctrl.alu_s1_sel       = (opcode == OPC_JAL) ? S1_PC : S1_REGVAL1;
               o_ctrl.alu_s2_sel       = S2_IMM;
               o_ctrl.write_reg        = 1'b1;
               o_ctrl.reg_input_sel    = RIN_ALU;
               o_ctrl.next_pc_from_alu = 1'b1;
               o_ctrl.next_stage       = STAGE_FETCH;
            end
            OPC_BRANCH: begin                 // compare rs1 vs rs2
               o_ctrl.next_stage = STAGE_BRANCH;
               case (funct3)
                  F3_BEQ:  o_ctrl.branch_mask[BR_BEQ]  = 1'b1;
                  F3_BNE:  o_ctrl.branch_mask[BR_BNE]  = 1'b1;
                  F3_BLT:  o_ctrl.branch_mask[BR_BLT]  = 1'b1;
                  F3_BGE:  o_ctrl.branch_mask[BR_BGE]  = 1'b1;
                  F3_BLTU: o_ctrl.branch_mask[BR_BLTU] = 1'b1;
                  F3_BGEU: o_ctrl.branch_mask[BR_BGEU] = 1'b1;
                  default: o_ctrl.branch_mask = '0;   // 010, 011 reserved
               endcase
            end
            OPC_AUIPC: begin                  // pc + upper imm
               o_ctrl.alu_s1_sel  = S1_PC;
               o_ctrl.alu_s2_sel  = S2_IMM;
               o_ctrl.wb_from_alu = 1'b1;
               o_ctrl.next_stage  = STAGE_FETCH;
            end
            OPC_LUI: begin
               o_ctrl.wb_from_imm   = 1'b1;
               o_ctrl.reg_input_sel = RIN_IMM;
               o_ctrl.next_stage    = STAGE_FETCH;
            end
            OPC_MISCMEM: o_ctrl.next_stage = STAGE_FETCH; // fence is a nop
            OPC_SYSTEM:  o_ctrl.next_stage = STAGE_SYSTEM;
            default:     o_ctrl.next_stage = STAGE_TRAP;
         endcase
      end
   end

   // a branch never tests two conditions at once
   a_mask_onehot : assert property (@(i_instr) $onehot0(o_ctrl.branch_mask))
      else $error("branch mask not one-hot: %b", o_ctrl.branch_mask);

   // illegal instr must not reach the register file
   a_trap_no_wb : assert property (@(i_instr)
      (o_ctrl.next_stage == STAGE_TRAP) |->
         !(o_ctrl.write_reg || o_ctrl.wb_from_alu || o_ctrl.wb_from_imm))
      else $error("trap with writeback flag set");

endmodule

// ==== src/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
   input  rv_decode_pkg::word_t i_instr,
   output rv_decode_pkg::word_t o_imm
);
   import rv_decode_pkg::*;

   opcode_e opcode;
   word_t   imm_i;                            // loads, op-imm, jalr, system
   word_t   imm_s;                            // stores
   word_t   imm_b;                            // branches
   word_t   imm_u;                            // lui, auipc
   word_t   imm_j;                            // jal

   assign opcode = opcode_e'(i_instr[6:2]);

   assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
   assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
   assign imm_b = {{19{i_instr[31]}},
                   i_instr[31],               // imm[12]
                   i_instr[7],                // imm[11]
                   i_instr[30:25],            // imm[10:5]
                   i_instr[11:8],             // imm[4:1]
                   1'b0};                     // halfword aligned
   assign imm_u = {i_instr[31:12], 12'b0};
   assign imm_j = {{11{i_instr[31]}},
                   i_instr[31],               // imm[20]
                   i_instr[19:12],            // imm[19:12]
                   i_instr[20],               // imm[11]
                   i_instr[30:21],            // imm[10:1]
                   1'b0};

   // format select from the opcode
   always_comb begin
      case (opcode)
         OPC_STORE:          o_imm = imm_s;
         OPC_BRANCH:         o_imm = imm_b;
         OPC_LUI, OPC_AUIPC: o_imm = imm_u;
         OPC_JAL:            o_imm = imm_j;
         default:            o_imm = imm_i; // meaningless for R-type
      endcase
   end

endmodule

// ==== src/rv_decode_pkg.sv ====
package rv_decode_pkg;

   typedef logic [31:0] word_t;               // instruction or data word
   typedef logic [4:0]  reg_idx_t;            // x0..x31

   localparam logic [1:0] LEN_32 = 2'b11;     // low bits of a full width instr

   // major opcodes, instr bits 6:2
   typedef enum logic [4:0] {
      OPC_LOAD    = 5'b00000,
      OPC_MISCMEM = 5'b00011,                 // fence
      OPC_OPIMM   = 5'b00100,
      OPC_AUIPC   = 5'b00101,
      OPC_STORE   = 5'b01000,
      OPC_OP      = 5'b01100,
      OPC_LUI     = 5'b01101,
      OPC_BRANCH  = 5'b11000,
      OPC_JALR    = 5'b11001,
      OPC_JAL     = 5'b11011,
      OPC_SYSTEM  = 5'b11100                  // ecall, ebreak, csr
   } opcode_e;

   localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
   localparam logic [6:0] FUNCT7_ALT    = 7'b0100000; // sub, sra
   localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // M extension

   // funct3 for OP and OP-IMM
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SRL_SRA = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   // funct3 for BRANCH, 010 and 011 unused
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   typedef enum logic [4:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
      ALU_OR, ALU_AND,
      ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU, // M extension multiplies
      ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU       // M extension divides
   } alu_op_e;

   typedef enum logic       {S1_REGVAL1, S1_PC} alu_s1_sel_e;
   typedef enum logic [1:0] {S2_REGVAL2, S2_IMM} alu_s2_sel_e;
   typedef enum logic [1:0] {RIN_ALU, RIN_IMM} reg_input_sel_e;

   typedef enum logic [2:0] {
      STAGE_FETCH,                            // done, writeback in fetch
      STAGE_LOAD,
      STAGE_STORE,
      STAGE_BRANCH,
      STAGE_SYSTEM,
      STAGE_TRAP                              // illegal instr
   } exec_stage_e;

   typedef logic [5:0] branch_mask_t;

   // branch mask bit positions
   localparam int BR_BEQ  = 0;
   localparam int BR_BNE  = 1;
   localparam int BR_BLT  = 2;
   localparam int BR_BGE  = 3;
   localparam int BR_BLTU = 4;
   localparam int BR_BGEU = 5;

   typedef struct packed {
      reg_idx_t rs1;
      reg_idx_t rs2;
      reg_idx_t rd;
   } reg_fields_t;

   typedef struct packed {
      alu_op_e        alu_op;
      alu_s1_sel_e    alu_s1_sel;
      alu_s2_sel_e    alu_s2_sel;
      reg_input_sel_e reg_input_sel;
      exec_stage_e    next_stage;
      logic           wb_from_alu;            // rd <= alu result in fetch
      logic           wb_from_imm;            // rd <= imm in fetch
      logic           next_pc_from_alu;       // jumps
      logic           write_reg;              // rd written during exec
      logic [2:0]     funct3;                 // load/store width etc
      branch_mask_t   branch_mask;
   } decode_ctrl_t;

endpackage

// ==== src/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder #(
   parameter bit ENABLE_M_EXT = 1'b1
) (
   input  logic                         i_clk,
   input  logic                         i_reset,
   input  logic                         i_en,     // one instr per strobe
   input  rv_decode_pkg::word_t         i_instr,
   output logic                         o_valid,  // result ready for one cycle
   output rv_decode_pkg::reg_fields_t   o_regs,
   output rv_decode_pkg::word_t         o_imm,
   output rv_decode_pkg::decode_ctrl_t  o_ctrl
);
   import rv_decode_pkg::*;

   word_t        imm_next;                    // comb decode results
   reg_fields_t  regs_next;
   decode_ctrl_t ctrl_next;

   imm_gen imm_gen_i (
      .i_instr (i_instr),
      .o_imm   (imm_next)
   );

   ctrl_decode #(
      .ENABLE_M_EXT (ENABLE_M_EXT)
   ) ctrl_decode_i (
      .i_instr (i_instr),
      .o_regs  (regs_next),
      .o_ctrl  (ctrl_next)
   );

   // result register held between strobes
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_valid <= 1'b0;
         o_regs  <= '0;
         o_imm   <= '0;
         o_ctrl  <= '0;                       // next_stage fetch and flags low
      end else begin
         o_valid <= i_en;                     // single cycle pulse per strobe
         if (i_en) begin
            o_regs <= regs_next;
            o_imm  <= imm_next;
            o_ctrl <= ctrl_next;
         end
      end
   end

   // each strobe gives exactly one valid a cycle later
   a_valid_follows_en : assert property (@(posedge i_clk) disable iff (i_reset)
      !$past(i_reset) |-> (o_valid == $past(i_en)))
      else $error("o_valid does not track i_en");

endmodule
